// ==== line_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module line_arbiter (
    input  logic                      clk,
    input  logic                      reset,
    input  mem_types_pkg::addr_t      icache_addr,
    input  logic                      icache_read,
    output mem_types_pkg::line_t      icache_data,
    output logic                      icache_resp,
    input  mem_types_pkg::addr_t      dcache_addr,
    input  mem_types_pkg::line_t      dcache_data_w,
    input  logic                      dcache_read,
    input  logic                      dcache_write,
    output mem_types_pkg::line_t      dcache_data_r,
    output logic                      dcache_resp,
    input  mem_types_pkg::addr_t      pc_rdata,
    output mem_types_pkg::line_addr_t lookup_addr,
    input  logic                      hit,
    input  mem_types_pkg::line_t      hit_data,
    output logic                      load,
    output mem_types_pkg::line_addr_t load_addr,
    output mem_types_pkg::line_t      load_data,
    output logic                      update,
    output mem_types_pkg::line_addr_t update_addr,
    output mem_types_pkg::line_t      update_data,
    line_port_if.requester            mem_port
);
    import mem_types_pkg::*;

    arb_state_t state;
    arb_state_t next_state;
    line_addr_t pf_target;   // Locked when a prefetch starts
    line_addr_t icache_line;
    line_addr_t dcache_line;
    logic       dcache_req;

    assign icache_line = icache_addr[`ADDR_BITS-1:`LINE_OFFSET_BITS];
    assign dcache_line = dcache_addr[`ADDR_BITS-1:`LINE_OFFSET_BITS];
    assign dcache_req  = dcache_read || dcache_write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // Line after the current pc, captured on the way into serve_prefetch
    always_ff @(posedge clk) begin
        if (state == idle) begin
            pf_target <= pc_rdata[`ADDR_BITS-1:`LINE_OFFSET_BITS] + line_addr_t'(1);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (icache_read) next_state = serve_icache;
                else if (dcache_req) next_state = serve_dcache;
                else next_state = serve_prefetch;
            end
            serve_icache: begin
                if (hit || mem_port.resp) begin
                    next_state = dcache_req ? serve_dcache : idle; // Data waited, serve it next
                end
            end
            serve_dcache: begin
                if (mem_port.resp) begin
                    next_state = icache_read ? serve_icache : idle;
                end
            end
            serve_prefetch: begin
                if (hit || mem_port.resp) next_state = idle; // Already buffered, or filled
            end
            default: next_state = idle;
        endcase
    end

    assign lookup_addr   = (state == serve_prefetch) ? pf_target : icache_line;
    assign icache_data   = hit ? hit_data : mem_port.data_r;
    assign dcache_data_r = mem_port.data_r;
    assign load_addr     = pf_target;
    assign load_data     = mem_port.data_r;
    assign update_addr   = dcache_line;
    assign update_data   = dcache_data_w;
    assign mem_port.data_w = dcache_data_w; // Only the data port writes

    always_comb begin
        icache_resp    = 1'b0;
        dcache_resp    = 1'b0;
        load           = 1'b0;
        update         = 1'b0;
        mem_port.addr  = '0;
        mem_port.read  = 1'b0;
        mem_port.write = 1'b0;
        case (state)
            serve_icache: begin
                mem_port.addr = icache_addr;
                if (hit) begin
                    icache_resp = 1'b1;       // Answered from the buffer
                end else begin
                    mem_port.read = icache_read;
                    icache_resp   = mem_port.resp;
                end
            end
            serve_dcache: begin
                mem_port.addr  = dcache_addr;
                mem_port.read  = dcache_read;
                mem_port.write = dcache_write;
                dcache_resp    = mem_port.resp;
                update         = dcache_write && mem_port.resp;
            end
            serve_prefetch: begin
                mem_port.addr = {pf_target, {`LINE_OFFSET_BITS{1'b0}}};
                mem_port.read = !hit;
                load          = mem_port.resp;
            end
            default: ;
        endcase
    end

    a_one_resp: assert property (@(posedge clk) disable iff (reset)
        !(icache_resp && dcache_resp))
        else $error("resp sent to both caches in one cycle");

    a_rw_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_port.read && mem_port.write))
        else $error("memory read and write requested together");

endmodule

`default_nettype wire

// ==== line_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module line_memory (
    input  logic           clk,
    input  logic           reset,
    line_port_if.responder port
);
    import mem_types_pkg::*;

    localparam int depth    = 1 << `MEM_LINES_LOG2;
    localparam int words    = `LINE_BITS / 32;
    localparam int cnt_bits = $clog2(`MEM_LATENCY + 1);

    line_t                      mem [depth];
    logic [cnt_bits-1:0]        cnt;
    logic [`MEM_LINES_LOG2-1:0] index;
    logic                       req;
    logic                       done;

    assign req   = port.read || port.write;
    assign index = port.addr[`LINE_OFFSET_BITS +: `MEM_LINES_LOG2];
    // Last waiting cycle, resp follows on the next edge
    assign done  = req && !port.resp && (cnt == cnt_bits'(`MEM_LATENCY - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt       <= '0;
            port.resp <= 1'b0;
            for (int i = 0; i < depth; i++) begin
                for (int w = 0; w < words; w++) begin
                    mem[i][w*32 +: 32] <= 32'(i * (`LINE_BITS / 8) + w * 4); // Own byte address
                end
            end
        end else begin
            port.resp <= done;
            if (done || port.resp || !req) begin
                cnt <= '0;                     // Idle, or request finished
            end else begin
                cnt <= cnt + cnt_bits'(1);
            end
            if (done && port.write) mem[index] <= port.data_w; // Visible in the resp cycle
        end
    end

    always_ff @(posedge clk) begin
        if (done && port.read) port.data_r <= mem[index];
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        req && !port.resp |=> $stable(port.addr))
        else $error("line memory address changed while a request was pending");

endmodule

`default_nettype wire

// ==== line_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One line-wide port: requester holds read or write until resp
interface line_port_if;
    import mem_types_pkg::*;

    addr_t addr;
    line_t data_w;
    logic  read;
    logic  write;
    line_t data_r; // Valid in the resp cycle
    logic  resp;   // One-cycle pulse

    modport requester (
        output addr,
        output data_w,
        output read,
        output write,
        input  data_r,
        input  resp
    );

    modport responder (
        input  addr,
        input  data_w,
        input  read,
        input  write,
        output data_r,
        output resp
    );

endinterface

`default_nettype wire

// ==== mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

`define LINE_BITS        256
`define ADDR_BITS        32
`define LINE_OFFSET_BITS 5
`define PF_ENTRIES       4
`define MEM_LINES_LOG2   6 // 64 lines, upper address bits ignored
`define MEM_LATENCY      4 // Request to resp, in cycles

`endif

// ==== mem_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
    input  logic                 clk,
    input  logic                 reset,
    input  mem_types_pkg::addr_t icache_addr,
    input  logic                 icache_read,
    output mem_types_pkg::line_t icache_data,
    output logic                 icache_resp,
    input  mem_types_pkg::addr_t dcache_addr,
    input  mem_types_pkg::line_t dcache_data_w,
    input  logic                 dcache_read,
    input  logic                 dcache_write,
    output mem_types_pkg::line_t dcache_data_r,
    output logic                 dcache_resp,
    input  mem_types_pkg::addr_t pc_rdata
);
    import mem_types_pkg::*;

    line_addr_t lookup_addr;
    logic       hit;
    line_t      hit_data;
    logic       load;
    line_addr_t load_addr;
    line_t      load_data;
    logic       update;
    line_addr_t update_addr;
    line_t      update_data;

    line_port_if mem_if ();

    line_arbiter arb0 (
        .clk           (clk),
        .reset         (reset),
        .icache_addr   (icache_addr),
        .icache_read   (icache_read),
        .icache_data   (icache_data),
        .icache_resp   (icache_resp),
        .dcache_addr   (dcache_addr),
        .dcache_data_w (dcache_data_w),
        .dcache_read   (dcache_read),
        .dcache_write  (dcache_write),
        .dcache_data_r (dcache_data_r),
        .dcache_resp   (dcache_resp),
        .pc_rdata      (pc_rdata),
        .lookup_addr   (lookup_addr),
        .hit           (hit),
        .hit_data      (hit_data),
        .load          (load),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .update        (update),
        .update_addr   (update_addr),
        .update_data   (update_data),
        .mem_port      (mem_if.requester)
    );

    prefetch_buffer pf_buf0 (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_data    (hit_data),
        .load        (load),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .update      (update),
        .update_addr (update_addr),
        .update_data (update_data)
    );

    line_memory mem0 (
        .clk   (clk),
        .reset (reset),
        .port  (mem_if.responder)
    );

endmodule

`default_nettype wire

// ==== mem_types_pkg.sv ====
`default_nettype none

`include "mem_defines.svh"

package mem_types_pkg;

    typedef logic [`ADDR_BITS-1:0] addr_t;

    // Eight 32-bit words, word 0 in the low bits
    typedef logic [`LINE_BITS-1:0] line_t;

    typedef logic [`ADDR_BITS-`LINE_OFFSET_BITS-1:0] line_addr_t; // Address without offset

    typedef enum logic [1:0] {
        idle,
        serve_icache,
        serve_dcache,
        serve_prefetch
    } arb_state_t;

endpackage

`default_nettype wire

// ==== prefetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module prefetch_buffer (
    input  logic                      clk,
    input  logic                      reset,
    input  mem_types_pkg::line_addr_t lookup_addr,
    output logic                      hit,
    output mem_types_pkg::line_t      hit_data,
    input  logic                      load,
    input  mem_types_pkg::line_addr_t load_addr,
    input  mem_types_pkg::line_t      load_data,
    input  logic                      update,
    input  mem_types_pkg::line_addr_t update_addr,
    input  mem_types_pkg::line_t      update_data
);
    import mem_types_pkg::*;

    localparam int idx_bits = $clog2(`PF_ENTRIES);

    logic [`PF_ENTRIES-1:0] valid;
    line_addr_t             tags  [`PF_ENTRIES];
    line_t                  lines [`PF_ENTRIES];
    logic [idx_bits-1:0]    rr_ptr;        // Next victim
    logic [`PF_ENTRIES-1:0] lookup_match;
    logic [`PF_ENTRIES-1:0] load_match;
    logic [`PF_ENTRIES-1:0] update_match;
    logic [idx_bits-1:0]    load_slot;
    logic                   dup_tag;

    // Tags are unique, so at most one bit of a match vector is set
    function automatic logic [idx_bits-1:0] match_idx(input logic [`PF_ENTRIES-1:0] m);
        logic [idx_bits-1:0] idx;
        idx = '0;
        for (int i = 0; i < `PF_ENTRIES; i++) begin
            if (m[i]) idx = idx_bits'(i);
        end
        return idx;
    endfunction

    for (genvar i = 0; i < `PF_ENTRIES; i++) begin : g_match
        assign lookup_match[i] = valid[i] && (tags[i] == lookup_addr);
        assign load_match[i]   = valid[i] && (tags[i] == load_addr);
        assign update_match[i] = valid[i] && (tags[i] == update_addr);
    end

    assign hit       = |lookup_match;
    assign hit_data  = lines[match_idx(lookup_match)];
    assign load_slot = (|load_match) ? match_idx(load_match) : rr_ptr; // Rewrite in place

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid  <= '0;
            rr_ptr <= '0;
        end else if (load) begin
            valid[load_slot] <= 1'b1;
            if (!(|load_match)) rr_ptr <= rr_ptr + idx_bits'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tags[load_slot]  <= load_addr;
            lines[load_slot] <= load_data;
        end else if (update && (|update_match)) begin
            lines[match_idx(update_match)] <= update_data; // Keep buffered copy coherent
        end
    end

    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < `PF_ENTRIES; i++) begin
            for (int j = i + 1; j < `PF_ENTRIES; j++) begin
                if (valid[i] && valid[j] && (tags[i] == tags[j])) dup_tag = 1'b1;
            end
        end
    end

    a_unique_tags: assert property (@(posedge clk) disable iff (reset) !dup_tag)
        else $error("prefetch buffer holds one line in two entries");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_mem_subsystem -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

// ==== sim.f ====
+incdir+.
mem_types_pkg.sv
line_port_if.sv
prefetch_buffer.sv
line_memory.sv
line_arbiter.sv
mem_subsystem_top.sv
tb_clock_gen.sv
tb_mem_subsystem.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0; // Released away from the active edge
    end

endmodule

`default_nettype wire

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module tb_mem_subsystem;
    import mem_types_pkg::*;

    localparam int mem_lines  = 1 << `MEM_LINES_LOG2;
    localparam int store_bits = `MEM_LINES_LOG2 + `LINE_OFFSET_BITS; // Byte address bits in use
    localparam int resp_limit = 50;
    localparam int n_random   = 40;
    localparam int n_rows     = 12 + n_random;

    logic  clk;
    logic  reset;
    addr_t icache_addr;
    logic  icache_read;
    line_t icache_data;
    logic  icache_resp;
    addr_t dcache_addr;
    line_t dcache_data_w;
    logic  dcache_read;
    logic  dcache_write;
    line_t dcache_data_r;
    logic  dcache_resp;
    addr_t pc_rdata;

    // Operation table, one row per access
    logic [7:0] row_client  [n_rows]; // "i", "d" or "b" for both
    logic       row_write   [n_rows];
    addr_t      row_addr    [n_rows];
    line_t      row_wdata   [n_rows];
    addr_t      row_pc      [n_rows];
    int         row_idle    [n_rows]; // Idle cycles before the request
    int         row_max_lat [n_rows]; // Resp deadline in cycles, 0 means none

    line_t       ref_mem [mem_lines];
    logic [31:0] lfsr;
    int          n_rows_used;
    int          checks;
    int          mismatches;
    int          failures;

    tb_clock_gen clk_gen0 (.clk(clk), .reset(reset));

    mem_subsystem_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .icache_addr   (icache_addr),
        .icache_read   (icache_read),
        .icache_data   (icache_data),
        .icache_resp   (icache_resp),
        .dcache_addr   (dcache_addr),
        .dcache_data_w (dcache_data_w),
        .dcache_read   (dcache_read),
        .dcache_write  (dcache_write),
        .dcache_data_r (dcache_data_r),
        .dcache_resp   (dcache_resp),
        .pc_rdata      (pc_rdata)
    );

    // Galois LFSR, one step per bit taken
    task automatic take_bits(input int n, output line_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[i] = lfsr[0];
            lfsr   = lfsr >> 1;
            if (val[i]) lfsr = lfsr ^ 32'h8020_0003;
        end
    endtask

    // Every word holds its own byte address
    function automatic line_t rule_line(input int index);
        line_t l;
        for (int w = 0; w < `LINE_BITS / 32; w++) begin
            l[w*32 +: 32] = 32'(index * (`LINE_BITS / 8) + w * 4);
        end
        return l;
    endfunction

    function automatic int line_index(input addr_t a);
        return int'(a[`LINE_OFFSET_BITS +: `MEM_LINES_LOG2]);
    endfunction

    task automatic check_value(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic add_row(input logic [7:0] client, input logic wr, input addr_t a,
                           input line_t d, input addr_t pc, input int idle, input int max_lat);
        row_client[n_rows_used]  = client;
        row_write[n_rows_used]   = wr;
        row_addr[n_rows_used]    = a;
        row_wdata[n_rows_used]   = d;
        row_pc[n_rows_used]      = pc;
        row_idle[n_rows_used]    = idle;
        row_max_lat[n_rows_used] = max_lat;
        n_rows_used++;
    endtask

    task automatic build_table();
        line_t bits;
        logic  is_d;
        logic  wr;
        addr_t a;
        addr_t pc;
        line_t d;
        // Fresh lines after reset
        add_row("i", 1'b0, 32'h0000_0000, '0, 32'h0000_0000, 0, 0);
        add_row("i", 1'b0, 32'h0000_00a4, '0, 32'h0000_0100, 0, 0);
        add_row("i", 1'b0, 32'h0000_07e0, '0, 32'h0000_0200, 0, 0);
        // Write, read back, neighbours untouched
        add_row("d", 1'b1, 32'h0000_0140, {4{64'hdead_beef_0bad_f00d}}, 32'h0000_0000, 0, 0);
        add_row("d", 1'b0, 32'h0000_0144, '0, 32'h0000_0000, 0, 0);
        add_row("d", 1'b0, 32'h0000_0160, '0, 32'h0000_0000, 0, 0);
        add_row("i", 1'b0, 32'h0000_0120, '0, 32'h0000_0000, 0, 0);
        // Next line after pc must come from the buffer
        add_row("i", 1'b0, 32'h0000_0320, '0, 32'h0000_0300, `MEM_LATENCY + 4, 2);
        // Prefetched line written by data port, then fetched
        add_row("d", 1'b1, 32'h0000_0420, {8{32'h1357_9bdf}}, 32'h0000_0400, `MEM_LATENCY + 4, 0);
        add_row("i", 1'b0, 32'h0000_0424, '0, 32'h0000_0400, 0, 2);
        // Both ports in the same cycle
        add_row("b", 1'b0, 32'h0000_01a0, '0, 32'h0000_0000, 0, 0);
        add_row("b", 1'b0, 32'h0000_05c8, '0, 32'h0000_0040, 0, 0);
        for (int k = 0; k < n_random; k++) begin
            take_bits(1, bits);
            is_d = bits[0];
            take_bits(1, bits);
            wr = is_d && bits[0];
            take_bits(store_bits - 2, bits);
            a = addr_t'({bits[store_bits-3:0], 2'b00}); // Word aligned, inside the store
            take_bits(store_bits, bits);
            pc = addr_t'(bits[store_bits-1:0]);
            d = '0;
            if (wr) take_bits(`LINE_BITS, d);
            add_row(is_d ? "d" : "i", wr, a, d, pc, 0, 0);
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset && cycles < 40) begin
            @(negedge clk);
            cycles++;
        end
        if (reset) report_failure("reset was never released");
        @(negedge clk);
    endtask

    task automatic run_row(input int r);
        line_t exp_line;
        logic  want_i;
        logic  want_d;
        logic  got_i;
        logic  got_d;
        int    cycles;
        pc_rdata = row_pc[r];
        repeat (row_idle[r]) @(negedge clk);
        want_i   = (row_client[r] == "i") || (row_client[r] == "b");
        want_d   = (row_client[r] == "d") || (row_client[r] == "b");
        exp_line = ref_mem[line_index(row_addr[r])]; // Contents before this row
        if (want_d && row_write[r]) ref_mem[line_index(row_addr[r])] = row_wdata[r];

        icache_addr   = row_addr[r];
        dcache_addr   = row_addr[r];
        dcache_data_w = row_wdata[r];
        icache_read   = want_i;
        dcache_read   = want_d && !row_write[r];
        dcache_write  = want_d && row_write[r];
        got_i  = !want_i;
        got_d  = !want_d;
        cycles = 0;
        while (!(got_i && got_d) && cycles < resp_limit) begin
            @(negedge clk);
            cycles++;
            // A request stays up through its resp cycle and drops in the next
            if (got_i) icache_read = 1'b0;
            if (got_d) begin
                dcache_read  = 1'b0;
                dcache_write = 1'b0;
            end
            if (icache_resp && dcache_resp) begin
                report_failure($sformatf("row %0d: both caches got resp in one cycle", r));
            end
            if (icache_resp && got_i) begin
                report_failure($sformatf("row %0d: icache_resp without a pending read", r));
            end else if (icache_resp) begin
                check_value("icache_data", icache_data, exp_line);
                if (row_max_lat[r] > 0 && cycles > row_max_lat[r]) begin
                    report_failure($sformatf("row %0d: icache_resp after %0d cycles, limit %0d",
                                             r, cycles, row_max_lat[r]));
                end
                got_i = 1'b1;
            end
            if (dcache_resp && got_d) begin
                report_failure($sformatf("row %0d: dcache_resp without a pending access", r));
            end else if (dcache_resp) begin
                if (!row_write[r]) check_value("dcache_data_r", dcache_data_r, exp_line);
                got_d = 1'b1;
            end
        end
        if (!(got_i && got_d)) begin
            report_failure($sformatf("row %0d: no resp within %0d cycles, arbiter in %s",
                                     r, resp_limit, dut0.arb0.state.name()));
        end
        @(negedge clk);
        icache_read  = 1'b0;
        dcache_read  = 1'b0;
        dcache_write = 1'b0;
        if (row_client[r] == "b") begin
            if (icache_resp || dcache_resp) report_failure($sformatf("row %0d: extra resp", r));
        end
    endtask

    initial begin
        icache_addr   = '0;
        icache_read   = 1'b0;
        dcache_addr   = '0;
        dcache_data_w = '0;
        dcache_read   = 1'b0;
        dcache_write  = 1'b0;
        pc_rdata      = '0;
        lfsr          = 32'h3a77_8963;
        n_rows_used   = 0;
        checks        = 0;
        mismatches    = 0;
        failures      = 0;
        for (int i = 0; i < mem_lines; i++) ref_mem[i] = rule_line(i);
        build_table();
        wait_reset_release();
        for (int r = 0; r < n_rows_used; r++) run_row(r);
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
